// File: cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cache geometry
// ----------------------------------------------------------------------
`define CACHE_SET_SIZE       4   // ways per set
`define CACHE_BLOCK_CAPACITY 32  // blocks in the whole cache
`define BW_WORD_ADDR         16  // host word address width
`define BW_BLOCK             2   // word offset inside a block

// derived widths
`define BW_GRP $clog2(`CACHE_SET_SIZE)                         // way index
`define BW_SET ($clog2(`CACHE_BLOCK_CAPACITY) - `BW_GRP)       // set index
`define BW_TAG (`BW_WORD_ADDR - `BW_SET - `BW_BLOCK)           // what is left

// apb register map (byte offsets)
// ----------------------------------------------------------------------
`define REG_ADDR   8'h00 // r/w, write starts a lookup
`define REG_STATUS 8'h04 // ro, last lookup result
`define REG_HITS   8'h08 // ro
`define REG_MISSES 8'h0C // ro
`define REG_CTRL   8'h10 // wo, bit 0 = flush

`endif

// File: cache_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

	// address fields
	// ------------------------------------------------------------------
	typedef logic [`BW_WORD_ADDR-1:0] word_addr_t; // full word address from the host
	typedef logic [`BW_TAG-1:0]       tag_t;       // upper address bits
	typedef logic [`BW_SET-1:0]       set_t;       // selects one set
	typedef logic [`BW_GRP-1:0]       way_t;       // selects one way inside a set

	// block location in the cache, {way, set}
	typedef logic [`BW_GRP+`BW_SET-1:0] cache_loc_t;

	// statistics
	typedef logic [15:0] count_t; // saturates never, wraps at 64k

	// lookup result
	// ------------------------------------------------------------------
	// first member sits at the msb, so read back from bit 0 the register
	// holds hit, loc, evict_valid, evict_tag
	typedef struct packed {
		tag_t       evict_tag;   // tag pushed out by the fill, zero if none
		logic       evict_valid; // a valid block was replaced
		cache_loc_t loc;         // hit location, or fill location on a miss
		logic       hit;         // tag found in the set
	} lookup_result_t;

endpackage

`default_nettype wire

// File: apb_pkg.sv
`default_nettype none

package apb_pkg;

	typedef logic [7:0]  apb_addr_t; // byte offset into the register map
	typedef logic [31:0] apb_data_t;

	// host to slave
	typedef struct packed {
		logic      psel;
		logic      penable; // high in the access phase
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// slave to host
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;  // ends the access phase
		logic      pslverr; // bad offset or write to a read-only register
	} apb_rsp_t;

	// controller sequence
	typedef enum logic [1:0] {
		IDLE,   // waiting for a setup phase
		LOOKUP, // addr write, directory searched this cycle
		DONE    // zero wait state transfer, response on the bus
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: way_priority_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module way_priority_encoder #(
	parameter int N_WAYS = 4
)(
	input  wire  [N_WAYS-1:0]    match_i, // one bit per way, tag equal and valid
	output cache_pkg::way_t      way_o,   // lowest matching way
	output logic                 valid_o  // any way matched
);

	// encoder
	// ------------------------------------------------------------------
	// walk from the top down so the lowest set bit wins
	always_comb begin
		way_o = '0;
		for (int w = N_WAYS-1; w >= 0; w--) begin
			if (match_i[w]) begin
				way_o = cache_pkg::way_t'(w);
			end
		end
	end

	assign valid_o = |match_i; // hit flag

	// fills only happen on a miss, so a tag never sits in two ways of a set
	always_comb begin
		if (!$isunknown(match_i)) begin
			assert ($onehot0(match_i))
				else $error("way_priority_encoder: tag present in more than one way %b", match_i);
		end
	end

endmodule

`default_nettype wire

// File: tag_memory_n_set.sv
`timescale 1ns/1ps
`default_nettype none

module tag_memory_n_set #(
	parameter int CACHE_SET_SIZE       = 4,
	parameter int CACHE_BLOCK_CAPACITY = 32
)(
	input  wire                    clock_i,
	input  wire                    resetn_i, // sync, active low, clears valid bits only
	input  wire                    wren_i,   // fill: write tag_i at add_i
	input  wire                    flush_i,  // drop every entry
	input  wire cache_pkg::set_t   set_i,    // set being searched
	input  wire cache_pkg::tag_t   tag_i,    // tag searched for, also the fill tag
	input  wire cache_pkg::cache_loc_t add_i, // fill location {way, set}
	output cache_pkg::cache_loc_t  add_o,    // hit location {way, set_i}
	output cache_pkg::tag_t        tag_o,    // tag stored at add_i
	output logic                   valid_o,  // valid bit at add_i
	output logic                   hit_o
);

	localparam int N_WAYS = CACHE_SET_SIZE;
	localparam int N_SETS = CACHE_BLOCK_CAPACITY / CACHE_SET_SIZE;

	// storage
	// ------------------------------------------------------------------
	cache_pkg::tag_t tag_mem [N_SETS][N_WAYS]; // block tags
	logic [N_WAYS-1:0] valid_q [N_SETS];       // one bit per way

	cache_pkg::way_t fill_way;     // way part of add_i
	cache_pkg::set_t fill_set;     // set part of add_i
	cache_pkg::way_t hit_way;
	logic [N_WAYS-1:0] match;      // compare result of the searched set

	assign fill_way = add_i[$bits(add_i)-1 -: $bits(fill_way)];
	assign fill_set = add_i[$bits(fill_set)-1:0];

	// victim side, read at the fill location
	assign tag_o   = tag_mem[fill_set][fill_way];
	assign valid_o = valid_q[fill_set][fill_way];

	// search
	// ------------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < N_WAYS; w++) begin
			match[w] = valid_q[set_i][w] && (tag_mem[set_i][w] == tag_i); // stale tags masked
		end
	end

	way_priority_encoder #(
		.N_WAYS (N_WAYS)
	) i_way_priority_encoder (
		.match_i (match),
		.way_o   (hit_way),
		.valid_o (hit_o)
	);

	assign add_o = {hit_way, set_i};

	// update
	// ------------------------------------------------------------------
	// tags are only meaningful behind a valid bit
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			tag_mem[fill_set][fill_way] <= tag_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < N_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (flush_i) begin
			for (int s = 0; s < N_SETS; s++) begin
				valid_q[s] <= '0; // whole directory empty next cycle
			end
		end else if (wren_i) begin
			valid_q[fill_set][fill_way] <= 1'b1;
		end
	end

	// controller never fills and flushes together, a fill would be lost
	assert property (@(posedge clock_i) disable iff (!resetn_i) !(wren_i && flush_i))
		else $error("tag_memory_n_set: fill and flush in the same cycle");

endmodule

`default_nettype wire

// File: victim_selector.sv
`timescale 1ns/1ps
`default_nettype none

module victim_selector #(
	parameter int N_SETS = 8,
	parameter int N_WAYS = 4
)(
	input  wire                  clock_i,
	input  wire                  resetn_i,  // sync, active low
	input  wire cache_pkg::set_t set_i,     // set of the current lookup
	input  wire                  advance_i, // a miss filled the shown way
	output cache_pkg::way_t      way_o      // next way to replace in set_i
);

	// round robin pointers
	// ------------------------------------------------------------------
	cache_pkg::way_t ptr_q [N_SETS]; // one per set, all start at way 0
	cache_pkg::way_t ptr_nxt;

	assign way_o = ptr_q[set_i];

	// step and wrap after the last way
	always_comb begin
		if (ptr_q[set_i] == cache_pkg::way_t'(N_WAYS-1)) begin
			ptr_nxt = '0;
		end else begin
			ptr_nxt = ptr_q[set_i] + 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < N_SETS; s++) begin
				ptr_q[s] <= '0;
			end
		end else if (advance_i) begin
			ptr_q[set_i] <= ptr_nxt; // other sets keep their pointer
		end
	end

endmodule

`default_nettype wire

// File: lookup_apb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module lookup_apb_ctrl (
	input  wire                        clock_i,
	input  wire                        resetn_i,     // sync, active low
	input  wire apb_pkg::apb_req_t     apb_req_i,
	output apb_pkg::apb_rsp_t          apb_rsp_o,
	output cache_pkg::set_t            set_o,        // to tag memory and victim selector
	output cache_pkg::tag_t            tag_o,
	output logic                       fill_en_o,    // write tag_o at fill_loc_o
	output cache_pkg::cache_loc_t      fill_loc_o,
	output logic                       flush_o,
	output logic                       advance_o,    // step the round robin of set_o
	input  wire cache_pkg::way_t       victim_way_i,
	input  wire                        hit_i,
	input  wire cache_pkg::cache_loc_t hit_loc_i,
	input  wire cache_pkg::tag_t       victim_tag_i, // current occupant of fill_loc_o
	input  wire                        victim_valid_i
);

	apb_pkg::ctrl_state_e      state_q;
	cache_pkg::word_addr_t     addr_q;    // last address written
	cache_pkg::lookup_result_t status_q;  // last lookup result
	cache_pkg::lookup_result_t result;
	cache_pkg::count_t         hits_q;
	cache_pkg::count_t         misses_q;
	apb_pkg::apb_data_t        rdata_q;   // read data captured at setup
	apb_pkg::apb_data_t        rd_data;
	logic                      slverr_q;
	logic                      bad_access;
	logic                      pready;
	logic                      setup;     // setup phase
	logic                      access;    // access phase
	logic                      xfer_end;  // transfer completes at this edge
	logic                      addr_wr;   // write to ADDR, needs a wait state
	logic                      lookup_end;

	// apb phases
	// ------------------------------------------------------------------
	assign setup    = apb_req_i.psel && !apb_req_i.penable;
	assign access   = apb_req_i.psel && apb_req_i.penable;
	assign pready   = (state_q != apb_pkg::IDLE); // idle is the wait state of an addr write
	assign xfer_end = access && pready;
	assign addr_wr  = apb_req_i.pwrite && (apb_req_i.paddr == `REG_ADDR);

	assign apb_rsp_o.prdata  = rdata_q;
	assign apb_rsp_o.pready  = pready;
	assign apb_rsp_o.pslverr = slverr_q;

	// register decode, read mux and error check
	always_comb begin
		rd_data    = '0;
		bad_access = 1'b0;
		case (apb_req_i.paddr)
			`REG_ADDR:   rd_data = 32'(addr_q);
			`REG_STATUS: begin
				rd_data    = 32'(status_q);
				bad_access = apb_req_i.pwrite; // read only
			end
			`REG_HITS: begin
				rd_data    = 32'(hits_q);
				bad_access = apb_req_i.pwrite;
			end
			`REG_MISSES: begin
				rd_data    = 32'(misses_q);
				bad_access = apb_req_i.pwrite;
			end
			`REG_CTRL:   rd_data = '0; // write only, reads as zero
			default:     bad_access = 1'b1;
		endcase
	end

	// directory side
	// ------------------------------------------------------------------
	assign tag_o      = addr_q[`BW_WORD_ADDR-1 -: `BW_TAG];
	assign set_o      = addr_q[`BW_BLOCK +: `BW_SET];
	assign fill_loc_o = {victim_way_i, set_o}; // round robin way in the same set

	assign lookup_end = (state_q == apb_pkg::LOOKUP) && xfer_end;
	assign fill_en_o  = lookup_end && !hit_i;
	assign advance_o  = lookup_end && !hit_i; // pointer moves with every fill
	assign flush_o    = (state_q == apb_pkg::DONE) && xfer_end && apb_req_i.pwrite
		&& (apb_req_i.paddr == `REG_CTRL) && !slverr_q && apb_req_i.pwdata[0];

	// what STATUS shows after this lookup
	always_comb begin
		result     = '0;
		result.hit = hit_i;
		if (hit_i) begin
			result.loc = hit_loc_i;
		end else begin
			result.loc         = fill_loc_o;
			result.evict_valid = victim_valid_i;
			result.evict_tag   = victim_valid_i ? victim_tag_i : '0; // no stale tags
		end
	end

	// sequencing
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q  <= apb_pkg::IDLE;
			rdata_q  <= '0;
			slverr_q <= 1'b0;
			status_q <= '0;
			hits_q   <= '0;
			misses_q <= '0;
		end else begin
			case (state_q)
				apb_pkg::IDLE: begin
					if (setup) begin
						rdata_q  <= rd_data;
						slverr_q <= bad_access;
						if (!addr_wr) begin
							state_q <= apb_pkg::DONE; // zero wait states
						end
					end else if (access && addr_wr) begin
						state_q <= apb_pkg::LOOKUP; // first access cycle, pready low
					end
				end
				apb_pkg::LOOKUP: begin
					if (xfer_end) begin
						state_q  <= apb_pkg::IDLE;
						status_q <= result; // current when the write completes
						if (hit_i) begin
							hits_q <= hits_q + 1'b1;
						end else begin
							misses_q <= misses_q + 1'b1;
						end
					end
				end
				apb_pkg::DONE: begin
					if (xfer_end) begin
						state_q  <= apb_pkg::IDLE;
						slverr_q <= 1'b0;
					end
				end
				default: state_q <= apb_pkg::IDLE;
			endcase
		end
	end

	// address register, loaded in the wait state of the addr write
	always_ff @(posedge clock_i) begin
		if ((state_q == apb_pkg::IDLE) && access && addr_wr) begin
			addr_q <= apb_req_i.pwdata[`BW_WORD_ADDR-1:0];
		end
	end

	// a response only ever answers the access phase of the host
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		apb_rsp_o.pready |-> (apb_req_i.psel && apb_req_i.penable))
		else $error("lookup_apb_ctrl: pready outside an access phase");

endmodule

`default_nettype wire

// File: cache_directory_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_directory_top (
	input  wire                    clock_i,
	input  wire                    resetn_i,  // sync, active low
	input  wire apb_pkg::apb_req_t apb_req_i, // only way into the directory
	output apb_pkg::apb_rsp_t      apb_rsp_o
);

	// controller to directory
	cache_pkg::set_t       set;
	cache_pkg::tag_t       tag;
	logic                  fill_en;
	cache_pkg::cache_loc_t fill_loc;
	logic                  flush;
	logic                  advance;
	// directory to controller
	cache_pkg::way_t       victim_way;
	logic                  hit;
	cache_pkg::cache_loc_t hit_loc;
	cache_pkg::tag_t       victim_tag;
	logic                  victim_valid;

	lookup_apb_ctrl i_lookup_apb_ctrl (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.apb_req_i      (apb_req_i),
		.apb_rsp_o      (apb_rsp_o),
		.set_o          (set),
		.tag_o          (tag),
		.fill_en_o      (fill_en),
		.fill_loc_o     (fill_loc),
		.flush_o        (flush),
		.advance_o      (advance),
		.victim_way_i   (victim_way),
		.hit_i          (hit),
		.hit_loc_i      (hit_loc),
		.victim_tag_i   (victim_tag),
		.victim_valid_i (victim_valid)
	);

	victim_selector #(
		.N_SETS (`CACHE_BLOCK_CAPACITY / `CACHE_SET_SIZE),
		.N_WAYS (`CACHE_SET_SIZE)
	) i_victim_selector (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.set_i     (set),
		.advance_i (advance),
		.way_o     (victim_way)
	);

	tag_memory_n_set #(
		.CACHE_SET_SIZE       (`CACHE_SET_SIZE),
		.CACHE_BLOCK_CAPACITY (`CACHE_BLOCK_CAPACITY)
	) i_tag_memory_n_set (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.wren_i   (fill_en),
		.flush_i  (flush),
		.set_i    (set),
		.tag_i    (tag),
		.add_i    (fill_loc),
		.add_o    (hit_loc),
		.tag_o    (victim_tag),
		.valid_o  (victim_valid),
		.hit_o    (hit)
	);

endmodule

`default_nettype wire

// File: tb_cache_directory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module tb_cache_directory;

	localparam int    CLK_PERIOD        = 40;
	localparam int    RESET_CYCLES      = 16;
	localparam int    CYCLES_PER_VECTOR = 20; // two transfers and a gap fit easily
	localparam int    MAX_WAIT          = 4;  // pready timeout of one transfer in cycles
	localparam string VECTOR_FILE       = "lookup_vectors.txt";

	// vector op codes
	localparam logic [3:0] OP_LOOKUP = 4'h0; // addr write then STATUS read
	localparam logic [3:0] OP_COUNTS = 4'h1; // HITS and MISSES read
	localparam logic [3:0] OP_FLUSH  = 4'h2; // CTRL write of bit 0
	localparam logic [3:0] OP_BAD_WR = 4'h3; // write that must return pslverr
	localparam logic [3:0] OP_BAD_RD = 4'h4; // read that must return pslverr

	typedef struct packed {
		logic [3:0]      op;
		logic [15:0]     addr;     // word address or the register offset of a bus error
		logic [15:0]     exp_hit;  // expected hit or HITS on a counter line
		logic [15:0]     exp_way;  // expected way or MISSES on a counter line
		logic            exp_evv;  // expected evicted-valid
		cache_pkg::tag_t exp_evtag;
	} vector_t;

	logic              clock;
	logic              resetn;
	apb_pkg::apb_req_t apb_req;
	apb_pkg::apb_rsp_t apb_rsp;
	vector_t           vectors[$];
	logic              loaded;      // vector file read so the watchdog may start
	logic              test_failed; // any check of the current test went wrong
	int                n_pass;
	int                n_fail;

	cache_directory_top i_cache_directory_top (
		.clock_i   (clock),
		.resetn_i  (resetn),
		.apb_req_i (apb_req),
		.apb_rsp_o (apb_rsp)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(CLK_PERIOD/2) clock = ~clock;
		end
	end

	// helpers
	// ------------------------------------------------------------------
	task automatic load_vectors();
		int fd;
		int n;
		string line;
		logic [3:0] op;
		logic [15:0] addr;
		logic [15:0] hit;
		logic [15:0] way;
		logic evv;
		cache_pkg::tag_t evtag;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			$display("cannot open %s", VECTOR_FILE);
			return;
		end
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%h %h %h %h %h %h", op, addr, hit, way, evv, evtag);
			if (n == 6) begin // comment and blank lines give no fields
				vectors.push_back('{op, addr, hit, way, evv, evtag});
			end
		end
		$fclose(fd);
	endtask

	// one full transfer that starts and ends on a falling edge
	task automatic apb_transfer(input logic write, input apb_pkg::apb_addr_t addr,
			input apb_pkg::apb_data_t wdata, output apb_pkg::apb_data_t rdata,
			output logic slverr, output logic stuck, output int waits);
		waits           = 0;
		apb_req.psel    = 1'b1; // setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clock);
		apb_req.penable = 1'b1; // access phase
		while (!apb_rsp.pready && waits < MAX_WAIT) begin
			@(negedge clock);
			waits++;
		end
		stuck  = !apb_rsp.pready;
		rdata  = apb_rsp.prdata;  // sampled half a cycle before the completing edge
		slverr = apb_rsp.pslverr;
		@(negedge clock);
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic idle_gap();
		int n;
		n = $urandom % 4; // zero gives back to back transfers
		repeat (n) @(negedge clock);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual == expected)
			else begin
				$display("ERR %s expected %h actual %h", name, expected, actual);
				test_failed = 1'b1;
			end
	endtask

	task automatic check_ready(input string name, input logic stuck);
		assert (!stuck)
			else begin
				$display("%s: pready stayed low, the transfer never completed", name);
				test_failed = 1'b1;
			end
	endtask

	// completion, wait states and error flag of one transfer
	task automatic check_response(input string name, input int exp_waits,
			input logic exp_slverr, input logic stuck, input int waits, input logic slverr);
		check_ready(name, stuck);
		check_value({name, " wait states"}, 32'(exp_waits), 32'(waits));
		check_value({name, " pslverr"}, 32'(exp_slverr), 32'(slverr));
	endtask

	// STATUS from bit 0 up holds hit, {way, set}, evicted-valid and evicted tag
	function automatic logic [31:0] expected_status(input vector_t v);
		cache_pkg::set_t set;
		// block number modulo the number of sets
		set = cache_pkg::set_t'((v.addr / (1 << `BW_BLOCK))
			% (`CACHE_BLOCK_CAPACITY / `CACHE_SET_SIZE));
		return {14'b0, v.exp_evtag, v.exp_evv, v.exp_way[1:0], set, v.exp_hit[0]};
	endfunction

	task automatic run_vector(input int idx, input vector_t v);
		apb_pkg::apb_data_t rdata;
		logic slverr;
		logic stuck;
		int waits;
		string name;
		test_failed = 1'b0;
		name        = $sformatf("vector %0d", idx);
		case (v.op)
			OP_LOOKUP: begin
				name = $sformatf("lookup %04h", v.addr);
				apb_transfer(1'b1, `REG_ADDR, 32'(v.addr), rdata, slverr, stuck, waits);
				check_response({name, " ADDR write"}, 1, 1'b0, stuck, waits, slverr);
				apb_transfer(1'b0, `REG_STATUS, '0, rdata, slverr, stuck, waits);
				check_response({name, " STATUS read"}, 0, 1'b0, stuck, waits, slverr);
				check_value({name, " STATUS"}, expected_status(v), rdata);
			end
			OP_COUNTS: begin
				name = $sformatf("counters at vector %0d", idx);
				apb_transfer(1'b0, `REG_HITS, '0, rdata, slverr, stuck, waits);
				check_response({name, " HITS read"}, 0, 1'b0, stuck, waits, slverr);
				check_value({name, " HITS"}, 32'(v.exp_hit), rdata);
				apb_transfer(1'b0, `REG_MISSES, '0, rdata, slverr, stuck, waits);
				check_response({name, " MISSES read"}, 0, 1'b0, stuck, waits, slverr);
				check_value({name, " MISSES"}, 32'(v.exp_way), rdata);
			end
			OP_FLUSH: begin
				name = "flush";
				apb_transfer(1'b1, `REG_CTRL, 32'h1, rdata, slverr, stuck, waits);
				check_response(name, 0, 1'b0, stuck, waits, slverr);
			end
			OP_BAD_WR, OP_BAD_RD: begin
				name = $sformatf("bus error %s %02h", (v.op == OP_BAD_WR) ? "write" : "read",
					v.addr[7:0]);
				apb_transfer(v.op == OP_BAD_WR, v.addr[7:0], 32'h1, rdata, slverr, stuck,
					waits);
				check_response(name, 0, 1'b1, stuck, waits, slverr);
			end
			default: begin
				$display("vector %0d has an unknown op code %h", idx, v.op);
				test_failed = 1'b1;
			end
		endcase
		if (test_failed) begin
			n_fail++;
		end else begin
			n_pass++;
		end
		$display("%s test %0d %s", test_failed ? "FAIL" : "ok  ", idx, name);
	endtask

	// main sequence
	// ------------------------------------------------------------------
	initial begin
		void'($urandom(64)); // seeds the idle gap lengths
		apb_req = '0;
		resetn  = 1'b0;
		loaded  = 1'b0;
		n_pass  = 0;
		n_fail  = 0;
		load_vectors();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		resetn = 1'b1;
		@(negedge clock);
		if (vectors.size() == 0) begin
			$display("no vectors were read from %s", VECTOR_FILE);
			n_fail++;
		end
		foreach (vectors[i]) begin
			run_vector(i, vectors[i]);
			idle_gap();
		end
		$display("%0d tests run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// watchdog sized from the vector count once the file is read
	initial begin
		int limit;
		wait (loaded);
		limit = RESET_CYCLES + (vectors.size() + 1) * CYCLES_PER_VECTOR;
		repeat (limit) @(posedge clock);
		$display("watchdog: run did not finish within %0d cycles", limit);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: lookup_vectors.txt
// op addr hit way evv evtag, all hex; op 0 lookup, 1 counters (hit = HITS, way = MISSES)
// op 2 flush, 3 write to offset addr and 4 read of offset addr, both expecting pslverr
// cold miss then hit, set 1
0 0024 0 0 0 000
0 0025 1 0 0 000
1 0000 1 1 0 000
// five tags into set 2, ways 0 1 2 3 0, then the first tag misses again
0 0208 0 0 0 000
0 0228 0 1 0 000
0 0248 0 2 0 000
0 0268 0 3 0 000
0 0288 0 0 1 010
0 0208 0 1 1 011
0 0268 1 3 0 000
1 0000 2 7 0 000
// sets 1 and 5 keep their own pointers
0 0024 1 0 0 000
0 fff4 0 0 0 000
0 0288 1 0 0 000
1 0000 4 8 0 000
// flush, round robin pointers survive it
2 0000 0 0 0 000
0 0024 0 1 0 000
0 0288 0 2 0 000
0 fff4 0 1 0 000
0 0208 0 3 0 000
0 0268 0 0 0 000
1 0000 4 d 0 000
// bus errors leave the counters alone
3 0020 0 0 0 000
4 0014 0 0 0 000
3 0004 0 0 0 000
3 000c 0 0 0 000
1 0000 4 d 0 000
0 0288 1 2 0 000
1 0000 5 d 0 000

// File: filelist.f
+incdir+.
cache_pkg.sv
apb_pkg.sv
way_priority_encoder.sv
tag_memory_n_set.sv
victim_selector.sv
lookup_apb_ctrl.sv
cache_directory_top.sv
tb_cache_directory.sv

// File: Makefile
# Verilator build and run for the cache directory testbench
# every variable can be overridden, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_cache_directory
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
